// ==== rtl/raycast_defines.svh ====
`ifndef RAYCAST_DEFINES_SVH
`define RAYCAST_DEFINES_SVH

// Maze grid coordinates and cell contents
`define GRID_X_W 6
`define GRID_Y_W 5
`define CELL_W 3

// Screen coordinates and pixel colour
`define VGA_X_W 8
`define VGA_Y_W 7
`define COLOUR_W 18

// Player pose fields
`define POS_X_W 14
`define POS_Y_W 13
`define ANGLE_W 8

// Reset coordinate, same on both axes
`define START_POS 384

// Frame pacing in clock cycles
`define FRAME_PERIOD 1700000
`define WRITE_WINDOW 3000

`endif

// ==== rtl/raycast_pkg.sv ====
`include "raycast_defines.svh"

package raycast_pkg;

    // One engine's access to the maze grid
    typedef struct packed {
        logic [`GRID_X_W-1:0] x;
        logic [`GRID_Y_W-1:0] y;
        logic                 write;
        logic [`CELL_W-1:0]   data;
    } grid_req_t;

    // One pixel write towards the VGA adapter
    typedef struct packed {
        logic [`VGA_X_W-1:0]  x;
        logic [`VGA_Y_W-1:0]  y;
        logic [`COLOUR_W-1:0] colour;
        logic                 write;
    } vga_px_t;

    typedef struct packed {
        logic [`POS_X_W-1:0] x;
        logic [`POS_Y_W-1:0] y;
        logic [`ANGLE_W-1:0] angle;
    } pose_t;

    typedef struct packed {
        logic turn_right;
        logic turn_left;
        logic forward;
        logic backward;
    } move_cmd_t;

    // One bit per phase engine, used for starts and dones alike
    typedef struct packed {
        logic level_load;
        logic draw_grid;
        logic draw_player;
        logic ray_cast;
        logic crosshair;
        logic player_update;
        logic enemy_update;
    } phase_set_t;

    typedef enum logic [2:0] {
        LOADER     = 3'd0,
        GRID_DRAW  = 3'd1,
        RAY        = 3'd2,
        PLAYER_UPD = 3'd3,
        ENEMY_UPD  = 3'd4,
        GRID_NONE  = 3'd7
    } grid_owner_e;

    typedef enum logic [1:0] {
        GRID_PIX   = 2'd0,
        PLAYER_PIX = 2'd1,
        CROSS_PIX  = 2'd2,
        PIX_NONE   = 2'd3
    } vga_owner_e;

endpackage

// ==== rtl/phase_sequencer.sv ====
module phase_sequencer (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      render_3d,
    input  raycast_pkg::phase_set_t   phase_done,
    output raycast_pkg::phase_set_t   phase_start,
    output raycast_pkg::grid_owner_e  grid_owner,
    output raycast_pkg::vga_owner_e   vga_owner,
    output logic                      load_pose,
    output logic                      store_pose
);
    import raycast_pkg::*;

    typedef enum logic [4:0] {
        S_RESET_POSE,
        S_LOAD,
        S_LOAD_WAIT,
        S_RENDER_CHECK,
        S_GRID,
        S_GRID_WAIT,
        S_PLAYER,
        S_PLAYER_WAIT,
        S_RAY,
        S_RAY_WAIT,
        S_CROSS,
        S_CROSS_WAIT,
        S_UPDATE,
        S_UPDATE_WAIT,
        S_STORE,
        S_ENEMY,
        S_ENEMY_WAIT
    } state_e;

    state_e state;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= S_RESET_POSE;
        end else begin
            case (state)
                S_RESET_POSE:   state <= S_LOAD;
                S_LOAD:         state <= S_LOAD_WAIT;
                S_LOAD_WAIT:    state <= phase_done.level_load ? S_RENDER_CHECK : S_LOAD_WAIT;
                // 3D mode skips every drawing phase
                S_RENDER_CHECK: state <= render_3d ? S_UPDATE : S_GRID;
                S_GRID:         state <= S_GRID_WAIT;
                S_GRID_WAIT:    state <= phase_done.draw_grid ? S_PLAYER : S_GRID_WAIT;
                S_PLAYER:       state <= S_PLAYER_WAIT;
                S_PLAYER_WAIT:  state <= phase_done.draw_player ? S_RAY : S_PLAYER_WAIT;
                S_RAY:          state <= S_RAY_WAIT;
                S_RAY_WAIT:     state <= phase_done.ray_cast ? S_CROSS : S_RAY_WAIT;
                S_CROSS:        state <= S_CROSS_WAIT;
                S_CROSS_WAIT:   state <= phase_done.crosshair ? S_UPDATE : S_CROSS_WAIT;
                S_UPDATE:       state <= S_UPDATE_WAIT;
                S_UPDATE_WAIT:  state <= phase_done.player_update ? S_STORE : S_UPDATE_WAIT;
                S_STORE:        state <= S_ENEMY;
                S_ENEMY:        state <= S_ENEMY_WAIT;
                S_ENEMY_WAIT:   state <= phase_done.enemy_update ? S_RENDER_CHECK : S_ENEMY_WAIT;
                default:        state <= S_RESET_POSE;
            endcase
        end
    end

    // One-cycle start pulses
    always_comb begin
        phase_start               = '0;
        phase_start.level_load    = (state == S_LOAD);
        phase_start.draw_grid     = (state == S_GRID);
        phase_start.draw_player   = (state == S_PLAYER);
        phase_start.ray_cast      = (state == S_RAY);
        phase_start.crosshair     = (state == S_CROSS);
        phase_start.player_update = (state == S_UPDATE);
        phase_start.enemy_update  = (state == S_ENEMY);
    end

    assign load_pose  = (state == S_RESET_POSE);
    assign store_pose = (state == S_STORE);

    // Port ownership only while an engine is busy
    always_comb begin
        case (state)
            S_LOAD_WAIT:   grid_owner = LOADER;
            S_GRID_WAIT:   grid_owner = GRID_DRAW;
            S_RAY_WAIT:    grid_owner = RAY;
            S_UPDATE_WAIT: grid_owner = PLAYER_UPD;
            S_ENEMY_WAIT:  grid_owner = ENEMY_UPD;
            default:       grid_owner = GRID_NONE;
        endcase
    end

    always_comb begin
        case (state)
            S_GRID_WAIT:   vga_owner = GRID_PIX;
            S_PLAYER_WAIT: vga_owner = PLAYER_PIX;
            S_CROSS_WAIT:  vga_owner = CROSS_PIX;
            default:       vga_owner = PIX_NONE;
        endcase
    end

    a_one_start: assert property (@(posedge clock) disable iff (reset)
        $onehot0(phase_start));

endmodule

// ==== rtl/grid_store.sv ====
`include "raycast_defines.svh"

module grid_store (
    input  logic                      clock,
    input  raycast_pkg::grid_owner_e  owner,
    input  raycast_pkg::grid_req_t    loader_grid,
    input  raycast_pkg::grid_req_t    draw_grid_req,
    input  raycast_pkg::grid_req_t    ray_grid,
    input  raycast_pkg::grid_req_t    upd_grid,
    input  raycast_pkg::grid_req_t    enemy_grid,
    output logic [`CELL_W-1:0]        rdata
);
    import raycast_pkg::*;

    localparam int ADDR_W = `GRID_X_W + `GRID_Y_W;

    grid_req_t           sel;
    logic [ADDR_W-1:0]   addr;
    logic [`CELL_W-1:0]  cells [0:(1 << ADDR_W) - 1];

    always_comb begin
        sel = '0;
        case (owner)
            LOADER: begin
                sel = loader_grid;
            end
            // Readers never write
            GRID_DRAW: begin
                sel       = draw_grid_req;
                sel.write = 1'b0;
                sel.data  = '0;
            end
            RAY: begin
                sel       = ray_grid;
                sel.write = 1'b0;
                sel.data  = '0;
            end
            PLAYER_UPD: begin
                sel       = upd_grid;
                sel.write = 1'b0;
                sel.data  = '0;
            end
            ENEMY_UPD: begin
                sel = enemy_grid;
            end
            default: begin
                sel = '0;
            end
        endcase
    end

    // Row-major cell address
    assign addr = {sel.y, sel.x};

    always_ff @(posedge clock) begin
        if (sel.write) begin
            cells[addr] <= sel.data;
        end
        rdata <= cells[addr];
    end

endmodule

// ==== rtl/vga_port_mux.sv ====
`include "raycast_defines.svh"

module vga_port_mux #(
    parameter int frame_period = `FRAME_PERIOD,
    parameter int write_window = `WRITE_WINDOW
) (
    input  logic                     clock,
    input  logic                     reset,
    input  raycast_pkg::vga_owner_e  owner,
    input  raycast_pkg::vga_px_t     grid_pix,
    input  raycast_pkg::vga_px_t     player_pix,
    input  raycast_pkg::vga_px_t     cross_pix,
    output raycast_pkg::vga_px_t     pixel
);
    import raycast_pkg::*;

    localparam int CNT_W = $clog2(frame_period + 1);

    logic [CNT_W-1:0] frame_count;
    logic             in_window;
    vga_px_t          sel;

    // Frame pacing, counts down to zero and reloads
    always_ff @(posedge clock) begin
        if (reset || frame_count == '0) begin
            frame_count <= CNT_W'(frame_period);
        end else begin
            frame_count <= frame_count - 1'b1;
        end
    end

    assign in_window = (frame_count < CNT_W'(write_window));

    always_comb begin
        case (owner)
            GRID_PIX:   sel = grid_pix;
            PLAYER_PIX: sel = player_pix;
            CROSS_PIX:  sel = cross_pix;
            default:    sel = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pixel <= '0;
        end else if (in_window) begin
            pixel <= sel;
        end else begin
            pixel <= '0;
        end
    end

    a_write_in_window: assert property (@(posedge clock) disable iff (reset)
        pixel.write |-> ($past(frame_count) < CNT_W'(write_window)));

endmodule

// ==== rtl/player_state.sv ====
`include "raycast_defines.svh"

module player_state (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    load_pose,
    input  logic                    store_pose,
    input  raycast_pkg::pose_t      next_pose,
    input  logic [17:0]             switches,
    input  logic [7:0]              key_press,
    output raycast_pkg::pose_t      pose,
    output raycast_pkg::move_cmd_t  move_cmd,
    output logic [5:0][6:0]         hex_digits
);
    import raycast_pkg::*;

    localparam pose_t START_POSE = '{
        x:     `POS_X_W'(`START_POS),
        y:     `POS_Y_W'(`START_POS),
        angle: '0
    };

    logic [5:0][3:0] nibbles;

    // Active-low segments, gfedcba
    function automatic logic [6:0] glyph(input logic [3:0] nibble);
        case (nibble)
            4'h0:    return 7'b1000000;
            4'h1:    return 7'b1111001;
            4'h2:    return 7'b0100100;
            4'h3:    return 7'b0110000;
            4'h4:    return 7'b0011001;
            4'h5:    return 7'b0010010;
            4'h6:    return 7'b0000010;
            4'h7:    return 7'b1111000;
            4'h8:    return 7'b0000000;
            4'h9:    return 7'b0010000;
            4'hA:    return 7'b0001000;
            4'hB:    return 7'b0000011;
            4'hC:    return 7'b1000110;
            4'hD:    return 7'b0100001;
            4'hE:    return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    always_ff @(posedge clock) begin
        if (reset || load_pose) begin
            pose <= START_POSE;
        end else if (store_pose) begin
            pose <= next_pose;
        end
    end

    // Key codes must match exactly, switches are plain levels
    assign move_cmd.turn_right = switches[1] | (key_press == 8'd8);
    assign move_cmd.turn_left  = switches[2] | (key_press == 8'd4);
    assign move_cmd.forward    = switches[3] | (key_press == 8'd1);
    assign move_cmd.backward   = switches[4] | (key_press == 8'd2);

    assign nibbles = {pose.x[7:4], pose.x[3:0],
                      pose.y[7:4], pose.y[3:0],
                      pose.angle[7:4], pose.angle[3:0]};

    always_comb begin
        for (int i = 0; i < 6; i++) begin
            hex_digits[i] = glyph(nibbles[i]);
        end
    end

endmodule

// ==== rtl/raycast_frame_top.sv ====
`include "raycast_defines.svh"

module raycast_frame_top #(
    parameter int frame_period = `FRAME_PERIOD,
    parameter int write_window = `WRITE_WINDOW
) (
    input  logic                     clock,
    input  logic                     reset,
    output raycast_pkg::phase_set_t  phase_start,
    input  raycast_pkg::phase_set_t  phase_done,
    input  raycast_pkg::grid_req_t   loader_grid,
    input  raycast_pkg::grid_req_t   draw_grid_req,
    input  raycast_pkg::grid_req_t   ray_grid,
    input  raycast_pkg::grid_req_t   upd_grid,
    input  raycast_pkg::grid_req_t   enemy_grid,
    output logic [`CELL_W-1:0]       grid_rdata,
    input  raycast_pkg::vga_px_t     grid_pix,
    input  raycast_pkg::vga_px_t     player_pix,
    input  raycast_pkg::vga_px_t     cross_pix,
    output raycast_pkg::vga_px_t     vga_out,
    input  raycast_pkg::pose_t       next_pose,
    output raycast_pkg::pose_t       pose,
    output raycast_pkg::move_cmd_t   move_cmd,
    input  logic [17:0]              switches,
    input  logic [7:0]               key_press,
    output logic [5:0][6:0]          hex_digits
);
    import raycast_pkg::*;

    grid_owner_e grid_owner;
    vga_owner_e  vga_owner;
    logic        load_pose;
    logic        store_pose;

    // Switch 17 selects first-person rendering
    phase_sequencer u_sequencer (
        .clock       (clock),
        .reset       (reset),
        .render_3d   (switches[17]),
        .phase_done  (phase_done),
        .phase_start (phase_start),
        .grid_owner  (grid_owner),
        .vga_owner   (vga_owner),
        .load_pose   (load_pose),
        .store_pose  (store_pose)
    );

    grid_store u_grid (
        .clock         (clock),
        .owner         (grid_owner),
        .loader_grid   (loader_grid),
        .draw_grid_req (draw_grid_req),
        .ray_grid      (ray_grid),
        .upd_grid      (upd_grid),
        .enemy_grid    (enemy_grid),
        .rdata         (grid_rdata)
    );

    vga_port_mux #(
        .frame_period (frame_period),
        .write_window (write_window)
    ) u_vga (
        .clock      (clock),
        .reset      (reset),
        .owner      (vga_owner),
        .grid_pix   (grid_pix),
        .player_pix (player_pix),
        .cross_pix  (cross_pix),
        .pixel      (vga_out)
    );

    player_state u_player (
        .clock      (clock),
        .reset      (reset),
        .load_pose  (load_pose),
        .store_pose (store_pose),
        .next_pose  (next_pose),
        .switches   (switches),
        .key_press  (key_press),
        .pose       (pose),
        .move_cmd   (move_cmd),
        .hex_digits (hex_digits)
    );

endmodule

// ==== verif/tb_checker.sv ====
`include "raycast_defines.svh"

module tb_checker #(
    parameter int frame_period = `FRAME_PERIOD,
    parameter int write_window = `WRITE_WINDOW
) (
    input  logic                    clock,
    input  logic                    reset,
    input  raycast_pkg::phase_set_t phase_start,
    input  raycast_pkg::phase_set_t phase_done,
    input  raycast_pkg::grid_req_t  draw_grid_req,
    input  raycast_pkg::grid_req_t  ray_grid,
    input  raycast_pkg::grid_req_t  enemy_grid,
    input  logic [`CELL_W-1:0]      grid_rdata,
    input  raycast_pkg::vga_px_t    grid_pix,
    input  raycast_pkg::vga_px_t    player_pix,
    input  raycast_pkg::vga_px_t    cross_pix,
    input  raycast_pkg::vga_px_t    vga_out,
    input  raycast_pkg::pose_t      next_pose,
    input  raycast_pkg::pose_t      pose,
    input  raycast_pkg::move_cmd_t  move_cmd,
    input  logic [17:0]             switches,
    input  logic [7:0]              key_press,
    input  logic [5:0][6:0]         hex_digits,
    output int                      errors,
    output int                      checks
);
    import raycast_pkg::*;

    localparam int XS = 1 << `GRID_X_W;
    localparam int YS = 1 << `GRID_Y_W;

    logic [`CELL_W-1:0] cells [YS][XS];
    logic [`CELL_W-1:0] exp_rdata;
    logic               rdata_pending;
    logic               store_pending;
    phase_set_t         last_start;
    phase_set_t         active;
    vga_px_t            exp_pixel;
    pose_t              exp_pose;
    int                 frame_count;

    initial begin
        errors = 0;
        checks = 0;
    end

    function automatic phase_set_t next_phase(input phase_set_t prev, input logic render_3d);
        phase_set_t nxt;
        nxt = '0;
        if (prev == '0) begin
            nxt.level_load = 1'b1;
        end else if (prev.level_load || prev.enemy_update) begin
            nxt.player_update = render_3d;
            nxt.draw_grid     = !render_3d;
        end else if (prev.draw_grid) begin
            nxt.draw_player = 1'b1;
        end else if (prev.draw_player) begin
            nxt.ray_cast = 1'b1;
        end else if (prev.ray_cast) begin
            nxt.crosshair = 1'b1;
        end else if (prev.crosshair) begin
            nxt.player_update = 1'b1;
        end else if (prev.player_update) begin
            nxt.enemy_update = 1'b1;
        end
        return nxt;
    endfunction

    function automatic logic [`CELL_W-1:0] cell_pattern(input int x, input int y);
        return `CELL_W'((x + y) % 8);
    endfunction

    // Lit segments gfedcba, inverted for the active-low display
    function automatic logic [6:0] glyph_of(input logic [3:0] value);
        logic [6:0] lit [16] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
                                 7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};
        return ~lit[value];
    endfunction

    function automatic move_cmd_t decode_move(input logic [17:0] sw, input logic [7:0] key);
        move_cmd_t cmd;
        cmd.turn_right = sw[1] || key == 8'd8;
        cmd.turn_left  = sw[2] || key == 8'd4;
        cmd.forward    = sw[3] || key == 8'd1;
        cmd.backward   = sw[4] || key == 8'd2;
        return cmd;
    endfunction

    function automatic pose_t start_pose();
        pose_t p;
        p.x     = `POS_X_W'(`START_POS);
        p.y     = `POS_Y_W'(`START_POS);
        p.angle = '0;
        return p;
    endfunction

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %s expected %0h got %0h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic fill_pattern();
        for (int y = 0; y < YS; y++) begin
            for (int x = 0; x < XS; x++) begin
                cells[y][x] = cell_pattern(x, y);
            end
        end
    endtask

    // Values seen here are the ones held during the cycle that this edge ends
    always @(posedge clock) begin : watch
        vga_px_t         owner_px;
        grid_req_t       rd_req;
        logic [5:0][6:0] exp_hex;
        if (reset) begin
            last_start    = '0;
            active        = '0;
            frame_count   = frame_period;
            exp_pixel     = '0;
            rdata_pending = 1'b0;
            store_pending = 1'b0;
            exp_pose      = start_pose();
        end else begin
            compare("vga_out", 64'(exp_pixel), 64'(vga_out));
            compare("pose", 64'(exp_pose), 64'(pose));
            exp_hex[5] = glyph_of(exp_pose.x[7:4]);
            exp_hex[4] = glyph_of(exp_pose.x[3:0]);
            exp_hex[3] = glyph_of(exp_pose.y[7:4]);
            exp_hex[2] = glyph_of(exp_pose.y[3:0]);
            exp_hex[1] = glyph_of(exp_pose.angle[7:4]);
            exp_hex[0] = glyph_of(exp_pose.angle[3:0]);
            compare("hex_digits", 64'(exp_hex), 64'(hex_digits));
            compare("move_cmd", 64'(decode_move(switches, key_press)), 64'(move_cmd));
            if (rdata_pending) begin
                compare("grid_rdata", 64'(exp_rdata), 64'(grid_rdata));
            end
            if (phase_start != '0) begin
                compare("phase_start", 64'(next_phase(last_start, switches[17])),
                        64'(phase_start));
                last_start = phase_start;
            end

            owner_px = '0;
            if (active.draw_grid) begin
                owner_px = grid_pix;
            end else if (active.draw_player) begin
                owner_px = player_pix;
            end else if (active.crosshair) begin
                owner_px = cross_pix;
            end
            exp_pixel   = (frame_count < write_window) ? owner_px : '0;
            frame_count = (frame_count == 0) ? frame_period : frame_count - 1;

            // Read returns the cell as it was before this edge
            rd_req        = active.draw_grid ? draw_grid_req : ray_grid;
            rdata_pending = active.draw_grid || active.ray_cast;
            exp_rdata     = cells[rd_req.y][rd_req.x];
            if (active.enemy_update && enemy_grid.write) begin
                cells[enemy_grid.y][enemy_grid.x] = enemy_grid.data;
            end
            if (active.level_load && phase_done.level_load) begin
                fill_pattern();
            end

            if (store_pending) begin
                exp_pose = next_pose;
            end
            store_pending = active.player_update && phase_done.player_update;

            if ((active & phase_done) != '0) begin
                active = '0;
            end
            if (phase_start != '0) begin
                active = phase_start;
            end
        end
    end

endmodule

// ==== verif/tb_top.sv ====
`include "raycast_defines.svh"

module tb_top;
    import raycast_pkg::*;

    localparam int FRAME_PERIOD = 200;
    localparam int WRITE_WINDOW = 30;
    localparam int FRAMES       = 8;
    localparam int MAX_DELAY    = 8;
    localparam int CELLS        = 1 << (`GRID_X_W + `GRID_Y_W);
    // Level load, then per frame up to eight states each needing start, wait and done
    localparam int TIMEOUT      = CELLS + FRAMES * 8 * (MAX_DELAY + 2) + 200;

    localparam int LOAD_BIT   = 6;
    localparam int GRID_BIT   = 5;
    localparam int PLAYER_BIT = 4;
    localparam int RAY_BIT    = 3;
    localparam int CROSS_BIT  = 2;
    localparam int UPD_BIT    = 1;
    localparam int ENEMY_BIT  = 0;

    logic            clock;
    logic            reset;
    phase_set_t      phase_start;
    phase_set_t      phase_done;
    grid_req_t       loader_grid, draw_grid_req, ray_grid, upd_grid, enemy_grid;
    logic [`CELL_W-1:0] grid_rdata;
    vga_px_t         grid_pix, player_pix, cross_pix, vga_out;
    pose_t           next_pose;
    pose_t           pose;
    move_cmd_t       move_cmd;
    logic [17:0]     switches;
    logic [7:0]      key_press;
    logic [5:0][6:0] hex_digits;

    // Behavioural engine state
    logic [6:0] busy;
    logic [6:0] done_bits;
    int         remain [7];
    int         load_addr;
    int         frames;
    int         cycles;
    logic       mode_3d;
    int         errors;
    int         checks;

    raycast_frame_top #(
        .frame_period (FRAME_PERIOD),
        .write_window (WRITE_WINDOW)
    ) UUT (
        .clock         (clock),
        .reset         (reset),
        .phase_start   (phase_start),
        .phase_done    (phase_done),
        .loader_grid   (loader_grid),
        .draw_grid_req (draw_grid_req),
        .ray_grid      (ray_grid),
        .upd_grid      (upd_grid),
        .enemy_grid    (enemy_grid),
        .grid_rdata    (grid_rdata),
        .grid_pix      (grid_pix),
        .player_pix    (player_pix),
        .cross_pix     (cross_pix),
        .vga_out       (vga_out),
        .next_pose     (next_pose),
        .pose          (pose),
        .move_cmd      (move_cmd),
        .switches      (switches),
        .key_press     (key_press),
        .hex_digits    (hex_digits)
    );

    tb_checker #(
        .frame_period (FRAME_PERIOD),
        .write_window (WRITE_WINDOW)
    ) u_checker (
        .clock         (clock),
        .reset         (reset),
        .phase_start   (phase_start),
        .phase_done    (phase_done),
        .draw_grid_req (draw_grid_req),
        .ray_grid      (ray_grid),
        .enemy_grid    (enemy_grid),
        .grid_rdata    (grid_rdata),
        .grid_pix      (grid_pix),
        .player_pix    (player_pix),
        .cross_pix     (cross_pix),
        .vga_out       (vga_out),
        .next_pose     (next_pose),
        .pose          (pose),
        .move_cmd      (move_cmd),
        .switches      (switches),
        .key_press     (key_press),
        .hex_digits    (hex_digits),
        .errors        (errors),
        .checks        (checks)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic grid_req_t random_cell(input logic may_write);
        grid_req_t req;
        req.x     = `GRID_X_W'($urandom());
        req.y     = `GRID_Y_W'($urandom());
        req.write = may_write & 1'($urandom());
        req.data  = `CELL_W'($urandom());
        return req;
    endfunction

    function automatic vga_px_t random_pixel();
        vga_px_t px;
        px.x      = `VGA_X_W'($urandom());
        px.y      = `VGA_Y_W'($urandom());
        px.colour = `COLOUR_W'($urandom());
        px.write  = 1'($urandom());
        return px;
    endfunction

    // Mostly the exact move codes, sometimes any byte
    function automatic logic [7:0] random_key();
        case ($urandom_range(5, 0))
            0:       return 8'd0;
            1:       return 8'd1;
            2:       return 8'd2;
            3:       return 8'd4;
            4:       return 8'd8;
            default: return 8'($urandom());
        endcase
    endfunction

    task automatic step_engines();
        logic [6:0] starts;
        logic [6:0] working;
        starts = phase_start;
        for (int i = 0; i < 7; i++) begin
            if (done_bits[i]) begin
                done_bits[i] = 1'b0;
                busy[i]      = 1'b0;
            end else if (starts[i]) begin
                busy[i]   = 1'b1;
                remain[i] = int'($urandom_range(MAX_DELAY - 1, 0));
                if (i == LOAD_BIT) begin
                    load_addr = 0;
                end
            end else if (busy[i] && !(i == LOAD_BIT && load_addr < CELLS)) begin
                if (remain[i] == 0) begin
                    done_bits[i] = 1'b1;
                end else begin
                    remain[i]--;
                end
            end
        end
        if (done_bits[ENEMY_BIT]) begin
            frames++;
        end
        mode_3d    = (frames >= FRAMES / 2);
        phase_done = phase_set_t'(done_bits);
        // Requests only after the start cycle
        working = busy & ~starts;

        loader_grid = '0;
        if (working[LOAD_BIT] && load_addr < CELLS) begin
            loader_grid.x     = load_addr[5:0];
            loader_grid.y     = load_addr[10:6];
            loader_grid.write = 1'b1;
            loader_grid.data  = `CELL_W'(load_addr[5:0] + load_addr[10:6]);
            load_addr++;
        end
        draw_grid_req = working[GRID_BIT]  ? random_cell(1'b0) : '0;
        ray_grid      = working[RAY_BIT]   ? random_cell(1'b0) : '0;
        upd_grid      = working[UPD_BIT]   ? random_cell(1'b1) : '0;
        enemy_grid    = working[ENEMY_BIT] ? random_cell(1'b1) : '0;
        grid_pix      = working[GRID_BIT]   ? random_pixel() : '0;
        player_pix    = working[PLAYER_BIT] ? random_pixel() : '0;
        cross_pix     = working[CROSS_BIT]  ? random_pixel() : '0;
        if (starts[UPD_BIT]) begin
            next_pose = pose_t'(35'({$urandom(), $urandom()}));
        end
        switches  = {mode_3d, 17'($urandom())};
        key_press = random_key();
    endtask

    initial begin
        void'($urandom(99260));
        reset         = 1'b1;
        phase_done    = '0;
        loader_grid   = '0;
        draw_grid_req = '0;
        ray_grid      = '0;
        upd_grid      = '0;
        enemy_grid    = '0;
        grid_pix      = '0;
        player_pix    = '0;
        cross_pix     = '0;
        next_pose     = '0;
        switches      = '0;
        key_press     = '0;
        busy          = '0;
        done_bits     = '0;
        load_addr     = 0;
        frames        = 0;
        cycles        = 0;
        mode_3d       = 1'b0;
        repeat (10) @(negedge clock);
        reset = 1'b0;
        while (frames < FRAMES && cycles < TIMEOUT) begin
            @(negedge clock);
            cycles++;
            step_engines();
        end
        if (frames >= FRAMES) begin
            repeat (4) begin
                @(negedge clock);
                step_engines();
            end
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (frames < FRAMES) begin
            $display("Timeout: only %0d of %0d frames finished in %0d cycles",
                     frames, FRAMES, cycles);
            $display(">>> FAIL");
        end else if (errors != 0) begin
            $display(">>> FAIL");
        end else begin
            $display(">>> PASS");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+rtl
rtl/raycast_pkg.sv
rtl/phase_sequencer.sv
rtl/grid_store.sv
rtl/vga_port_mux.sv
rtl/player_state.sv
rtl/raycast_frame_top.sv
verif/tb_checker.sv
verif/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the frame controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_top -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

exit 0
